// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_load_subsystem
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

// File: flist.f
+incdir+include
verilog/lsu_pkg.sv
verilog/load_align.sv
verilog/load_unit.sv
verilog/store_queue.sv
verilog/data_ram.sv
verilog/load_subsystem.sv
tests/load_checker.sv
tests/load_monitor.sv
tests/tb_load_subsystem.sv

// File: include/lsu_defs.svh
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// ####################################################################
// datapath widths
// ####################################################################

`define LSU_XLEN        64                   // data and address width
`define LSU_PREG_W      6                    // physical register tag
`define LSU_ROB_LOG     5                    // rob index, id adds a wrap bit

// ####################################################################
// store queue and data ram
// ####################################################################

`define LSU_SQ_LOG      3                    // sq index, id adds a wrap bit
`define LSU_SQ_DEPTH    (1 << `LSU_SQ_LOG)

`define LSU_RAM_LOG     6                    // doublewords, log2
`define LSU_RAM_DEPTH   (1 << `LSU_RAM_LOG)
`define LSU_RAM_LATENCY 3                    // accepted read to done

`endif

// File: tests/load_checker.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsu_defs.svh"

module load_checker (
    input  wire                       clock,
    input  wire                       reset_n,
    input  wire lsu_pkg::load_state_e state,
    input  wire                       issue_valid,
    input  wire                       issue_ready,
    input  wire                       wb_valid,
    input  wire                       store_valid,
    input  wire                       queue_full
);

    // ####################################################################
    // load fsm
    // ####################################################################

    // an accepted load is held, so ready must drop on the next edge
    ready_low_after_accept: assert property (@(posedge clock) disable iff (!reset_n)
        (issue_valid && issue_ready) |=> (state == lsu_pkg::TAKEIN && !issue_ready))
        else $error("issue_ready high while a load is held");

    wb_ends_load: assert property (@(posedge clock) disable iff (!reset_n)
        wb_valid |=> (state == lsu_pkg::IDLE && !wb_valid))
        else $error("load still held after its writeback");

    // ####################################################################
    // store queue
    // ####################################################################

    no_store_when_full: assert property (@(posedge clock) disable iff (!reset_n)
        queue_full |-> !store_valid)
        else $error("store_valid arrived while the store queue was full");

endmodule

bind load_unit load_checker u_fsm_checker (
    .clock       (clock),
    .reset_n     (reset_n),
    .state       (state),
    .issue_valid (issue_valid),
    .issue_ready (issue_ready),
    .wb_valid    (wb_valid),
    .store_valid (1'b0),
    .queue_full  (1'b0)
);

bind store_queue load_checker u_queue_checker (
    .clock       (clock),
    .reset_n     (reset_n),
    .state       (lsu_pkg::IDLE),
    .issue_valid (1'b0),
    .issue_ready (1'b1),
    .wb_valid    (1'b0),
    .store_valid (store_valid),
    .queue_full  (count[`LSU_SQ_LOG])         // count equals depth only when msb set
);

`default_nettype wire

// File: tests/load_monitor.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsu_defs.svh"

module load_monitor (
    input  wire                     clock,
    input  wire                     reset_n,
    input  wire                     issue_valid,
    input  wire                     issue_ready,
    input  wire                     wb_valid,
    input  wire lsu_pkg::load_wb_t  wb,
    input  wire lsu_pkg::sqid_t     sq_tail,
    input  wire lsu_pkg::load_wb_t  exp_wb,
    input  wire                     exp_fwd,
    input  wire                     exp_killed,
    input  wire lsu_pkg::sqid_t     exp_tail,
    output int                      pass_count,
    output int                      fail_count
);

    localparam int TIMEOUT = 50;

    lsu_pkg::load_wb_t held;
    logic              held_fwd;
    logic              held_killed;
    logic              held_tail_ok;
    logic              pending;
    int                cycles;
    int                load_no;

    initial begin
        pass_count = 0;
        fail_count = 0;
        pending    = 1'b0;
        load_no    = 0;
    end

    function automatic bit compare_field(string name, lsu_pkg::xlen_t expv,
                                         lsu_pkg::xlen_t got);
        if (expv !== got) begin
            $display("error at %0t: %s expected %h got %h", $time, name, expv, got);
            return 1'b0;
        end
        return 1'b1;
    endfunction

    function automatic void record_result(bit ok, string how);
        if (ok) pass_count++;
        else    fail_count++;
        $display("load %0d %s (%s)", load_no, ok ? "passed" : "failed", how);
    endfunction

    // ####################################################################
    // writeback compare, one load in flight at a time
    // ####################################################################

    always @(posedge clock) begin
        bit ok;
        if (reset_n) begin
            if (pending) begin
                cycles++;                                   // cycles since acceptance
                if (wb_valid) begin
                    pending = 1'b0;
                    if (held_killed) begin
                        record_result(1'b0, "writeback from a flushed load");
                    end else begin
                        ok = compare_field("wb.data", held.data, wb.data);
                        ok &= compare_field("wb.pc", held.pc, wb.pc);
                        ok &= compare_field("wb.prd", lsu_pkg::xlen_t'(held.prd),
                                            lsu_pkg::xlen_t'(wb.prd));
                        ok &= compare_field("wb.robid", lsu_pkg::xlen_t'(held.robid),
                                            lsu_pkg::xlen_t'(wb.robid));
                        ok &= held_tail_ok;
                        if (held_fwd && cycles != 1) begin
                            $display("forwarded load took %0d cycles instead of 1", cycles);
                            ok = 1'b0;
                        end
                        if (!held_fwd && cycles < 1 + `LSU_RAM_LATENCY) begin
                            $display("ram load finished after %0d cycles, before rd_done", cycles);
                            ok = 1'b0;
                        end
                        record_result(ok, held_fwd ? "forwarded" : "from ram");
                    end
                end else if (held_killed && issue_ready) begin
                    pending = 1'b0;
                    record_result(held_tail_ok, "flushed, no writeback");
                end else if (cycles > TIMEOUT) begin
                    pending = 1'b0;
                    record_result(1'b0, "no writeback within the timeout");
                end
            end else if (wb_valid) begin
                $display("writeback at %0t with no load in flight", $time);
                fail_count++;
            end
            if (issue_valid && issue_ready) begin           // expectation travels with issue
                held         = exp_wb;
                held_fwd     = exp_fwd;
                held_killed  = exp_killed;
                held_tail_ok = compare_field("sq_tail", lsu_pkg::xlen_t'(exp_tail),
                                             lsu_pkg::xlen_t'(sq_tail));
                pending      = 1'b1;
                cycles       = 0;
                load_no++;
            end
        end
    end

endmodule

`default_nettype wire

// File: tests/tb_load_subsystem.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsu_defs.svh"

module tb_load_subsystem;

    localparam int TIMEOUT = 50;              // cycles per wait
    localparam int N_OPS   = 600;

    logic                  clock;
    logic                  reset_n;
    logic                  issue_valid;
    lsu_pkg::load_issue_t  issue;
    logic                  issue_ready;
    logic                  store_valid;
    lsu_pkg::store_write_t store;
    logic                  store_commit;
    lsu_pkg::sqid_t        sq_tail;
    logic                  flush_valid;
    lsu_pkg::robid_t       flush_robid;
    logic                  wb_valid;
    lsu_pkg::load_wb_t     wb;

    lsu_pkg::load_wb_t     exp_wb;
    logic                  exp_fwd;
    logic                  exp_killed;
    lsu_pkg::sqid_t        exp_tail;
    int                    pass_count;
    int                    fail_count;

    lsu_pkg::xlen_t        model_mem [`LSU_RAM_DEPTH];
    lsu_pkg::store_write_t model_sq [$];      // oldest at index 0
    lsu_pkg::sqid_t        model_head;
    int                    n_loads;
    bit                    hung;

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;            // 4 ns period
    end

    load_subsystem dut0 (
        .clock        (clock),
        .reset_n      (reset_n),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .issue_ready  (issue_ready),
        .store_valid  (store_valid),
        .store        (store),
        .store_commit (store_commit),
        .sq_tail      (sq_tail),
        .flush_valid  (flush_valid),
        .flush_robid  (flush_robid),
        .wb_valid     (wb_valid),
        .wb           (wb)
    );

    load_monitor mon0 (
        .clock       (clock),
        .reset_n     (reset_n),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .wb_valid    (wb_valid),
        .wb          (wb),
        .sq_tail     (sq_tail),
        .exp_wb      (exp_wb),
        .exp_fwd     (exp_fwd),
        .exp_killed  (exp_killed),
        .exp_tail    (exp_tail),
        .pass_count  (pass_count),
        .fail_count  (fail_count)
    );

    // ####################################################################
    // reference model
    // ####################################################################

    function automatic int size_bytes(lsu_pkg::ls_size_e s);
        case (s)
            lsu_pkg::BYTE: return 1;
            lsu_pkg::HALF: return 2;
            lsu_pkg::WORD: return 4;
            default:       return 8;
        endcase
    endfunction

    // pick the addressed bytes, then fill the upper bytes with the sign
    function automatic lsu_pkg::xlen_t extend_load(lsu_pkg::xlen_t dword, int off,
                                                   int nbytes, bit uns);
        lsu_pkg::xlen_t v;
        v = '0;
        for (int i = 0; i < nbytes; i++) begin
            v[8*i +: 8] = dword[8*(off+i) +: 8];
        end
        if (!uns && v[8*nbytes-1]) begin
            for (int i = nbytes; i < 8; i++) begin
                v[8*i +: 8] = 8'hff;
            end
        end
        return v;
    endfunction

    function automatic bit covers_bytes(lsu_pkg::byte_mask_t mask, int off, int nbytes);
        for (int i = off; i < off + nbytes; i++) begin
            if (!mask[i]) return 1'b0;
        end
        return 1'b1;
    endfunction

    function automatic lsu_pkg::xlen_t pick_address();
        int idx;
        if ($urandom % 4 == 0) idx = $urandom % `LSU_RAM_DEPTH;
        else                   idx = $urandom % 8;     // small set so stores and loads meet
        return lsu_pkg::xlen_t'(idx) << 3;
    endfunction

    function automatic lsu_pkg::byte_mask_t pick_mask();
        case ($urandom % 4)
            0:       return 8'hff;
            1:       return lsu_pkg::byte_mask_t'($urandom);
            2:       return 8'h0f << (4 * ($urandom % 2));
            default: return 8'h03 << (2 * ($urandom % 4));
        endcase
    endfunction

    function automatic void apply_commit();
        lsu_pkg::store_write_t st;
        int                    idx;
        if (model_sq.size() > 0) begin
            st  = model_sq.pop_front();
            idx = st.address[`LSU_RAM_LOG+2:3];
            for (int b = 0; b < 8; b++) begin
                if (st.mask[b]) model_mem[idx][8*b +: 8] = st.data[8*b +: 8];
            end
            model_head++;
        end
    endfunction

    // ####################################################################
    // stimulus
    // ####################################################################

    task automatic push_store();
        lsu_pkg::store_write_t st;
        st.address  = pick_address();
        st.data     = {$urandom, $urandom};
        st.mask     = pick_mask();
        store       = st;
        store_valid = 1'b1;
        @(posedge clock);
        #1;
        store_valid = 1'b0;
        model_sq.push_back(st);
    endtask

    task automatic commit_oldest();
        store_commit = 1'b1;
        @(posedge clock);
        #1;
        store_commit = 1'b0;
        apply_commit();
    endtask

    task automatic issue_load();
        lsu_pkg::load_issue_t ld;
        lsu_pkg::xlen_t       addr;
        lsu_pkg::xlen_t       dword;
        lsu_pkg::robid_t      frob;
        logic [11:0]          imm12;
        int                   nbytes;
        int                   off;
        int                   younger;
        int                   older;
        bit                   hit;
        bit                   commit_now;
        bit                   flush_now;
        bit                   kill;
        ld.size        = lsu_pkg::ls_size_e'($urandom % 4);
        nbytes         = size_bytes(ld.size);
        off            = ($urandom % (8 / nbytes)) * nbytes;   // aligned only
        addr           = pick_address() + lsu_pkg::xlen_t'(off);
        imm12          = 12'($urandom);
        ld.imm         = {{52{imm12[11]}}, imm12};
        ld.base        = addr - ld.imm;
        ld.pc          = {$urandom, $urandom};
        ld.prd         = lsu_pkg::preg_t'($urandom);
        ld.robid       = lsu_pkg::robid_t'($urandom);
        ld.is_unsigned = 1'($urandom);
        younger        = 0;
        if (model_sq.size() > 0 && $urandom % 4 == 0) younger = 1 + $urandom % model_sq.size();
        older          = model_sq.size() - younger;
        ld.sqid        = model_head + lsu_pkg::sqid_t'(older);
        exp_tail       = model_head + lsu_pkg::sqid_t'(model_sq.size());
        hit            = 1'b0;
        for (int j = older - 1; j >= 0 && !hit; j--) begin      // youngest older store first
            if (model_sq[j].address[`LSU_XLEN-1:3] == addr[`LSU_XLEN-1:3] &&
                covers_bytes(model_sq[j].mask, off, nbytes)) begin
                hit   = 1'b1;
                dword = model_sq[j].data;
            end
        end
        commit_now = ($urandom % 4 == 0);     // lands while the load is in TAKEIN
        if (commit_now) apply_commit();
        if (!hit) dword = model_mem[addr[`LSU_RAM_LOG+2:3]];
        flush_now = ($urandom % 6 == 0);
        kill      = flush_now && ($urandom % 2 == 1);
        if (kill) frob = ld.robid - lsu_pkg::robid_t'(1 + $urandom % 15);
        else      frob = ld.robid + lsu_pkg::robid_t'($urandom % 16);
        exp_wb.pc    = ld.pc;
        exp_wb.prd   = ld.prd;
        exp_wb.robid = ld.robid;
        exp_wb.data  = extend_load(dword, off, nbytes, ld.is_unsigned);
        exp_fwd      = hit;
        exp_killed   = kill;
        issue        = ld;
        issue_valid  = 1'b1;
        @(posedge clock);
        #1;
        issue_valid  = 1'b0;
        store_commit = commit_now;
        flush_valid  = flush_now;
        flush_robid  = frob;
        @(posedge clock);
        #1;
        store_commit = 1'b0;
        flush_valid  = 1'b0;
        n_loads++;
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (!issue_ready && n < TIMEOUT) begin
            @(posedge clock);
            #1;
            n++;
        end
        if (!issue_ready) begin
            $display("timeout at %0t: issue_ready stayed low for %0d cycles", $time, TIMEOUT);
            hung = 1'b1;
        end
    endtask

    initial begin
        int pick;
        int n;
        void'($urandom(32'h469d_6a1a));
        reset_n      = 1'b0;
        issue_valid  = 1'b0;
        issue        = '0;
        store_valid  = 1'b0;
        store        = '0;
        store_commit = 1'b0;
        flush_valid  = 1'b0;
        flush_robid  = '0;
        exp_wb       = '0;
        exp_fwd      = 1'b0;
        exp_killed   = 1'b0;
        exp_tail     = '0;
        model_head   = '0;
        n_loads      = 0;
        hung         = 1'b0;
        for (int i = 0; i < `LSU_RAM_DEPTH; i++) begin
            model_mem[i] = '0;
        end
        repeat (3) @(posedge clock);
        #1;
        reset_n = 1'b1;
        for (int op = 0; op < N_OPS && !hung; op++) begin
            pick = $urandom % 10;
            if (pick < 3 && model_sq.size() < `LSU_SQ_DEPTH) push_store();
            else if (pick < 5)                                commit_oldest();
            else                                              issue_load();
            wait_ready();
        end
        n = 0;
        while (pass_count + fail_count < n_loads && n < TIMEOUT) begin
            @(posedge clock);
            #1;
            n++;
        end
        if (pass_count + fail_count < n_loads) begin
            $display("timeout: %0d loads never finished", n_loads - pass_count - fail_count);
            hung = 1'b1;
        end
        $display("loads: %0d issued, %0d passed, %0d failed", n_loads, pass_count, fail_count);
        if (!hung && fail_count == 0 && pass_count == n_loads) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/data_ram.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsu_defs.svh"

module data_ram (
    input  wire                        clock,
    input  wire                        reset_n,
    input  wire                        rd_valid,
    input  wire lsu_pkg::xlen_t        rd_addr,
    output logic                       rd_ready,
    output logic                       rd_done,
    output lsu_pkg::xlen_t             rd_data,
    input  wire                        wr_en,
    input  wire lsu_pkg::store_write_t wr
);

    lsu_pkg::xlen_t               mem [`LSU_RAM_DEPTH];
    logic [`LSU_RAM_LATENCY-1:0]  vld_pipe;
    logic [`LSU_RAM_LOG-1:0]      idx_pipe [`LSU_RAM_LATENCY];
    logic [`LSU_RAM_LOG-1:0]      wr_idx;

    assign rd_ready = !wr_en;                          // commit write owns the cycle
    assign rd_done  = vld_pipe[`LSU_RAM_LATENCY-1];
    assign rd_data  = mem[idx_pipe[`LSU_RAM_LATENCY-1]];
    assign wr_idx   = wr.address[`LSU_RAM_LOG+2:3];    // doubleword index

    // read latency chain
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe <= {vld_pipe[`LSU_RAM_LATENCY-2:0], rd_valid & rd_ready};
        end
    end

    always_ff @(posedge clock) begin
        idx_pipe[0] <= rd_addr[`LSU_RAM_LOG+2:3];
        for (int s = 1; s < `LSU_RAM_LATENCY; s++) begin
            idx_pipe[s] <= idx_pipe[s-1];
        end
    end

    // array is zeroed on reset, then written a byte lane at a time
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < `LSU_RAM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            for (int b = 0; b < `LSU_XLEN/8; b++) begin
                if (wr.mask[b]) mem[wr_idx][8*b +: 8] <= wr.data[8*b +: 8];
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/load_align.sv
`timescale 1ns/1ps
`default_nettype none

module load_align (
    input  wire lsu_pkg::xlen_t    dword,
    input  wire logic [2:0]        offset,
    input  wire lsu_pkg::ls_size_e size,
    input  wire logic              is_unsigned,
    output lsu_pkg::xlen_t         result
);

    lsu_pkg::xlen_t shifted;
    logic           sign_b;
    logic           sign_h;
    logic           sign_w;

    assign shifted = dword >> {offset, 3'b000};  // addressed lane down to bit 0

    // sign bits drop to zero for unsigned loads
    assign sign_b = shifted[7] & ~is_unsigned;
    assign sign_h = shifted[15] & ~is_unsigned;
    assign sign_w = shifted[31] & ~is_unsigned;

    always_comb begin
        case (size)
            lsu_pkg::BYTE:   result = {{56{sign_b}}, shifted[7:0]};
            lsu_pkg::HALF:   result = {{48{sign_h}}, shifted[15:0]};
            lsu_pkg::WORD:   result = {{32{sign_w}}, shifted[31:0]};
            lsu_pkg::DOUBLE: result = dword;     // full width, nothing to extend
            default:         result = dword;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/load_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module load_subsystem (
    input  wire                        clock,
    input  wire                        reset_n,
    input  wire                        issue_valid,
    input  wire lsu_pkg::load_issue_t  issue,
    output logic                       issue_ready,
    input  wire                        store_valid,
    input  wire lsu_pkg::store_write_t store,
    input  wire                        store_commit,
    output lsu_pkg::sqid_t             sq_tail,
    input  wire                        flush_valid,
    input  wire lsu_pkg::robid_t       flush_robid,
    output logic                       wb_valid,
    output lsu_pkg::load_wb_t          wb
);

    lsu_pkg::fwd_req_t     fwd_req;
    lsu_pkg::fwd_resp_t    fwd_resp;
    logic                  rd_valid;
    lsu_pkg::xlen_t        rd_addr;
    logic                  rd_ready;
    logic                  rd_done;
    lsu_pkg::xlen_t        rd_data;
    logic                  wr_en;
    lsu_pkg::store_write_t wr;

    load_unit u_load_unit (
        .clock       (clock),
        .reset_n     (reset_n),
        .issue_valid (issue_valid),
        .issue       (issue),
        .issue_ready (issue_ready),
        .flush_valid (flush_valid),
        .flush_robid (flush_robid),
        .fwd_req     (fwd_req),
        .fwd_resp    (fwd_resp),
        .rd_valid    (rd_valid),
        .rd_addr     (rd_addr),
        .rd_ready    (rd_ready),
        .rd_done     (rd_done),
        .rd_data     (rd_data),
        .wb_valid    (wb_valid),
        .wb          (wb)
    );

    store_queue u_store_queue (
        .clock        (clock),
        .reset_n      (reset_n),
        .store_valid  (store_valid),
        .store        (store),
        .store_commit (store_commit),
        .sq_tail      (sq_tail),
        .fwd_req      (fwd_req),
        .fwd_resp     (fwd_resp),
        .wr_en        (wr_en),
        .wr           (wr)
    );

    data_ram u_data_ram (
        .clock    (clock),
        .reset_n  (reset_n),
        .rd_valid (rd_valid),
        .rd_addr  (rd_addr),
        .rd_ready (rd_ready),
        .rd_done  (rd_done),
        .rd_data  (rd_data),
        .wr_en    (wr_en),
        .wr       (wr)
    );

endmodule

`default_nettype wire

// File: verilog/load_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsu_defs.svh"

module load_unit (
    input  wire                       clock,
    input  wire                       reset_n,
    input  wire                       issue_valid,
    input  wire lsu_pkg::load_issue_t issue,
    output logic                      issue_ready,
    input  wire                       flush_valid,
    input  wire lsu_pkg::robid_t      flush_robid,
    output lsu_pkg::fwd_req_t         fwd_req,
    input  wire lsu_pkg::fwd_resp_t   fwd_resp,
    output logic                      rd_valid,
    output lsu_pkg::xlen_t            rd_addr,
    input  wire                       rd_ready,
    input  wire                       rd_done,
    input  wire lsu_pkg::xlen_t       rd_data,
    output logic                      wb_valid,
    output lsu_pkg::load_wb_t         wb
);

    lsu_pkg::load_state_e state;
    lsu_pkg::load_state_e state_nxt;

    logic issue_fire;
    logic rd_fire;
    logic fwd_hit;
    logic ram_done;
    logic kill;

    lsu_pkg::xlen_t    pc_q;
    lsu_pkg::preg_t    prd_q;
    lsu_pkg::robid_t   robid_q;
    lsu_pkg::sqid_t    sqid_q;
    lsu_pkg::xlen_t    addr_q;
    lsu_pkg::ls_size_e size_q;
    logic              unsigned_q;
    lsu_pkg::xlen_t    align_in;
    lsu_pkg::xlen_t    load_data;

    // ####################################################################
    // issue latch and address generation
    // ####################################################################

    assign issue_ready = (state == lsu_pkg::IDLE);
    assign issue_fire  = issue_valid & issue_ready;

    always_ff @(posedge clock) begin
        if (issue_fire) begin
            pc_q       <= issue.pc;
            prd_q      <= issue.prd;
            robid_q    <= issue.robid;
            sqid_q     <= issue.sqid;
            addr_q     <= issue.base + issue.imm;   // agu
            size_q     <= issue.size;
            unsigned_q <= issue.is_unsigned;
        end
    end

    assign fwd_req.valid   = (state != lsu_pkg::IDLE);  // query while a load is held
    assign fwd_req.sqid    = sqid_q;
    assign fwd_req.address = addr_q;
    assign fwd_req.size    = size_q;

    // killed when the held load is younger than the flushing instruction
    assign kill = flush_valid && (state != lsu_pkg::IDLE) &&
                  ((flush_robid[`LSU_ROB_LOG] ^ robid_q[`LSU_ROB_LOG]) ^
                   (flush_robid[`LSU_ROB_LOG-1:0] < robid_q[`LSU_ROB_LOG-1:0]));

    // ####################################################################
    // bus request and fsm
    // ####################################################################

    assign fwd_hit  = (state == lsu_pkg::TAKEIN) && fwd_resp.hit;
    assign ram_done = (state == lsu_pkg::OUTSTANDING) && rd_done;  // stale done ignored
    assign rd_valid = !kill && (((state == lsu_pkg::TAKEIN) && !fwd_resp.hit) ||
                                (state == lsu_pkg::PENDING));
    assign rd_addr  = addr_q;
    assign rd_fire  = rd_valid & rd_ready;

    always_comb begin
        state_nxt = state;
        case (state)
            lsu_pkg::IDLE: begin
                if (issue_fire) state_nxt = lsu_pkg::TAKEIN;
            end
            lsu_pkg::TAKEIN: begin
                if (fwd_resp.hit) state_nxt = lsu_pkg::IDLE;       // done via forwarding
                else if (rd_fire) state_nxt = lsu_pkg::OUTSTANDING;
                else              state_nxt = lsu_pkg::PENDING;    // ram busy with a commit
            end
            lsu_pkg::PENDING: begin
                if (rd_fire) state_nxt = lsu_pkg::OUTSTANDING;
            end
            lsu_pkg::OUTSTANDING: begin
                if (rd_done) state_nxt = lsu_pkg::IDLE;
            end
            default: state_nxt = lsu_pkg::IDLE;
        endcase
        if (kill) state_nxt = lsu_pkg::IDLE;
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state <= lsu_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // ####################################################################
    // writeback select
    // ####################################################################

    assign align_in = (state == lsu_pkg::TAKEIN) ? fwd_resp.data : rd_data;

    load_align u_load_align (
        .dword       (align_in),
        .offset      (addr_q[2:0]),
        .size        (size_q),
        .is_unsigned (unsigned_q),
        .result      (load_data)
    );

    assign wb_valid = !kill && (fwd_hit || ram_done);
    assign wb.pc    = pc_q;
    assign wb.prd   = prd_q;
    assign wb.robid = robid_q;
    assign wb.data  = load_data;

endmodule

`default_nettype wire

// File: verilog/lsu_pkg.sv
`default_nettype none
`include "lsu_defs.svh"

package lsu_pkg;

    typedef logic [`LSU_XLEN-1:0]   xlen_t;
    typedef logic [`LSU_PREG_W-1:0] preg_t;
    typedef logic [`LSU_ROB_LOG:0]  robid_t;      // msb is the wrap bit
    typedef logic [`LSU_SQ_LOG:0]   sqid_t;       // msb is the wrap bit
    typedef logic [`LSU_XLEN/8-1:0] byte_mask_t;  // one bit per byte lane

    typedef enum logic [1:0] {BYTE, HALF, WORD, DOUBLE} ls_size_e;

    typedef enum logic [1:0] {IDLE, TAKEIN, PENDING, OUTSTANDING} load_state_e;

    typedef struct packed {
        xlen_t    pc;
        preg_t    prd;
        robid_t   robid;
        sqid_t    sqid;          // stores before this id are older
        xlen_t    base;
        xlen_t    imm;
        ls_size_e size;
        logic     is_unsigned;
    } load_issue_t;

    typedef struct packed {
        logic     valid;
        sqid_t    sqid;
        xlen_t    address;
        ls_size_e size;
    } fwd_req_t;

    typedef struct packed {
        logic  hit;
        xlen_t data;             // store bytes sit in their own lanes
    } fwd_resp_t;

    typedef struct packed {
        xlen_t      address;
        xlen_t      data;        // lane position, not shifted down
        byte_mask_t mask;
    } store_write_t;

    typedef struct packed {
        xlen_t  pc;
        preg_t  prd;
        robid_t robid;
        xlen_t  data;
    } load_wb_t;

endpackage

`default_nettype wire

// File: verilog/store_queue.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsu_defs.svh"

module store_queue (
    input  wire                        clock,
    input  wire                        reset_n,
    input  wire                        store_valid,
    input  wire lsu_pkg::store_write_t store,
    input  wire                        store_commit,
    output lsu_pkg::sqid_t             sq_tail,
    input  wire lsu_pkg::fwd_req_t     fwd_req,
    output lsu_pkg::fwd_resp_t         fwd_resp,
    output logic                       wr_en,
    output lsu_pkg::store_write_t      wr
);

    lsu_pkg::store_write_t entries [`LSU_SQ_DEPTH];
    lsu_pkg::sqid_t        head;
    lsu_pkg::sqid_t        tail;
    lsu_pkg::sqid_t        count;
    lsu_pkg::sqid_t        older_cnt;
    lsu_pkg::byte_mask_t   need_mask;

    assign count   = tail - head;                       // wrap bit makes full distinct
    assign sq_tail = tail;
    assign wr_en   = store_commit && (count != '0);
    assign wr      = entries[head[`LSU_SQ_LOG-1:0]];    // oldest entry drains

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            head <= '0;
            tail <= '0;
        end else begin
            if (store_valid) tail <= tail + 1'b1;
            if (wr_en)       head <= head + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (store_valid) entries[tail[`LSU_SQ_LOG-1:0]] <= store;
    end

    // ####################################################################
    // forwarding search
    // ####################################################################

    always_comb begin
        case (fwd_req.size)
            lsu_pkg::BYTE:   need_mask = 8'h01 << fwd_req.address[2:0];
            lsu_pkg::HALF:   need_mask = 8'h03 << fwd_req.address[2:0];
            lsu_pkg::WORD:   need_mask = 8'h0f << fwd_req.address[2:0];
            default:         need_mask = 8'hff;
        endcase
    end

    assign older_cnt = fwd_req.sqid - head;   // entries between head and the load

    always_comb begin : fwd_search
        lsu_pkg::sqid_t        idx;
        lsu_pkg::store_write_t ent;
        fwd_resp = '0;
        for (int k = 0; k < `LSU_SQ_DEPTH; k++) begin   // oldest first, youngest wins
            idx = head + lsu_pkg::sqid_t'(k);
            ent = entries[idx[`LSU_SQ_LOG-1:0]];
            if (fwd_req.valid && (older_cnt <= count) && (k < older_cnt) &&
                (ent.address[`LSU_XLEN-1:3] == fwd_req.address[`LSU_XLEN-1:3]) &&
                ((ent.mask & need_mask) == need_mask)) begin
                fwd_resp.hit  = 1'b1;
                fwd_resp.data = ent.data;
            end
        end
    end

endmodule

`default_nettype wire
